//--- fir_dsp_pkg.sv
`default_nettype none

package fir_dsp_pkg;

  // stream sample width
  parameter int unsigned SAMPLE_W = 16;

  // filter coefficient width
  parameter int unsigned COEFF_W = 16;

  // accumulator width
  // 16 products of 32 bits fit without overflow
  parameter int unsigned ACC_W = 40;

  // one stream sample
  typedef logic [SAMPLE_W-1:0] sample_t;

  // one coefficient
  typedef logic [COEFF_W-1:0] coeff_t;

  // running sum and final result
  typedef logic [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

//--- fir_bus_pkg.sv
`default_nettype none

package fir_bus_pkg;

  // wishbone byte address and data widths
  parameter int unsigned WB_ADR_W = 8;
  parameter int unsigned WB_DAT_W = 32;

  typedef logic [WB_ADR_W-1:0] wb_adr_t;
  typedef logic [WB_DAT_W-1:0] wb_data_t;

  // region codes in address bits 7:6, code 3 unmapped
  parameter logic [1:0] REGION_REGS    = 2'd0;
  parameter logic [1:0] REGION_SAMPLES = 2'd1;
  parameter logic [1:0] REGION_COEFFS  = 2'd2;

  // register word offsets, address bits 5:2
  parameter logic [3:0] REG_STATUS = 4'd0;
  parameter logic [3:0] REG_SAMPLE = 4'd1;
  parameter logic [3:0] REG_Y_LO   = 4'd2;
  parameter logic [3:0] REG_Y_HI   = 4'd3;
  parameter logic [3:0] REG_SHIFT  = 4'd4;

endpackage

`default_nettype wire

//--- wb_region_decode.sv
`timescale 1ns/1ps
`default_nettype none

module wb_region_decode
  import fir_bus_pkg::*;
(
  input  wire           clk_i,
  input  wire           rst_ni,
  input  wire           cyc_i,
  input  wire           stb_i,
  input  wire wb_adr_t  adr_i,
  // bit 0 regs, bit 1 samples, bit 2 coeffs
  output logic [2:0]    sel_o,
  input  wire wb_data_t dat_regs_i,
  input  wire wb_data_t dat_smp_i,
  input  wire wb_data_t dat_coef_i,
  input  wire           ack_regs_i,
  input  wire           ack_smp_i,
  input  wire           ack_coef_i,
  output wb_data_t      dat_o,
  output logic          ack_o
);

  logic [1:0] region;
  logic       req;
  logic       none_req;
  logic       none_ack_q;

  // region lives in the top two address bits
  assign region = adr_i[7:6];
  assign req    = cyc_i & stb_i;

  // select fan-out and response mux
  always_comb begin
    sel_o    = '0;
    none_req = 1'b0;
    dat_o    = '0;
    ack_o    = none_ack_q;
    case (region)
      REGION_REGS: begin
        sel_o[0] = req;
        dat_o    = dat_regs_i;
        ack_o    = ack_regs_i;
      end
      REGION_SAMPLES: begin
        sel_o[1] = req;
        dat_o    = dat_smp_i;
        ack_o    = ack_smp_i;
      end
      REGION_COEFFS: begin
        sel_o[2] = req;
        dat_o    = dat_coef_i;
        ack_o    = ack_coef_i;
      end
      // unmapped, acked here with zero data
      default: none_req = req;
    endcase
  end

  // single-cycle ack for unmapped accesses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      none_ack_q <= 1'b0;
    end else begin
      none_ack_q <= none_req & ~none_ack_q;
    end
  end

endmodule

`default_nettype wire

//--- fir_sample_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fir_sample_ram
  import fir_dsp_pkg::*;
  import fir_bus_pkg::*;
#(
  parameter int unsigned LOG2_TAPS = 4
) (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  // engine side
  input  wire                 wr_en_i,
  input  wire [LOG2_TAPS-1:0] wr_idx_i,
  input  wire sample_t        wr_data_i,
  input  wire [LOG2_TAPS-1:0] rd_idx_i,
  output sample_t             rd_data_o,
  // bus side, read only
  input  wire                 wb_sel_i,
  input  wire                 wb_we_i,
  input  wire [3:0]           wb_off_i,
  output wb_data_t            wb_dat_o,
  output logic                wb_ack_o
);

  localparam int unsigned TAPS = 2 ** LOG2_TAPS;

  sample_t mem_q [TAPS];
  logic    req;

  // new request seen, ack not yet given
  assign req = wb_sel_i & ~wb_ack_o;

  // circular storage, engine writes and reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q     <= '{default: '0};
      rd_data_o <= '0;
    end else begin
      if (wr_en_i) begin
        mem_q[wr_idx_i] <= wr_data_i;
      end
      rd_data_o <= mem_q[rd_idx_i];
    end
  end

  // bus reads registered, writes acked and dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end else begin
      wb_ack_o <= req;
      if (req) begin
        if (!wb_we_i && wb_off_i < TAPS) begin
          wb_dat_o <= wb_data_t'(mem_q[wb_off_i[LOG2_TAPS-1:0]]);
        end else begin
          wb_dat_o <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- fir_coeff_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fir_coeff_ram
  import fir_dsp_pkg::*;
  import fir_bus_pkg::*;
#(
  parameter int unsigned LOG2_TAPS = 4
) (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  // engine read by tap index
  input  wire [LOG2_TAPS-1:0] rd_idx_i,
  output coeff_t              rd_data_o,
  // bus side
  input  wire                 wb_sel_i,
  input  wire                 wb_we_i,
  input  wire [3:0]           wb_off_i,
  input  wire wb_data_t       wb_dat_i,
  output wb_data_t            wb_dat_o,
  output logic                wb_ack_o
);

  localparam int unsigned TAPS = 2 ** LOG2_TAPS;

  coeff_t mem_q [TAPS];
  logic   req;
  logic   hit;

  assign req = wb_sel_i & ~wb_ack_o;
  // offsets past the last tap read zero
  assign hit = (wb_off_i < TAPS);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q     <= '{default: '0};
      rd_data_o <= '0;
      wb_ack_o  <= 1'b0;
      wb_dat_o  <= '0;
    end else begin
      rd_data_o <= mem_q[rd_idx_i];
      wb_ack_o  <= req;
      if (req) begin
        // write lands on the ack edge, low half only
        if (wb_we_i && hit) begin
          mem_q[wb_off_i[LOG2_TAPS-1:0]] <= wb_dat_i[COEFF_W-1:0];
        end
        if (!wb_we_i && hit) begin
          wb_dat_o <= wb_data_t'(mem_q[wb_off_i[LOG2_TAPS-1:0]]);
        end else begin
          wb_dat_o <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- fir_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fir_regs
  import fir_dsp_pkg::*;
  import fir_bus_pkg::*;
(
  input  wire           clk_i,
  input  wire           rst_ni,
  input  wire           wb_sel_i,
  input  wire           wb_we_i,
  input  wire [3:0]     wb_off_i,
  input  wire wb_data_t wb_dat_i,
  output wb_data_t      wb_dat_o,
  output logic          wb_ack_o,
  // sample injection towards the engine
  output logic          inject_o,
  output sample_t       inject_sample_o,
  // engine status and results
  input  wire           busy_i,
  input  wire           drop_i,
  input  wire           y_valid_i,
  input  wire acc_t     y_i,
  input  wire sample_t  shift_i
);

  logic    req;
  logic    overrun_q;
  acc_t    y_q;
  sample_t shift_q;

  assign req = wb_sel_i & ~wb_ack_o;

  // bus access, data registered with the ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o        <= 1'b0;
      wb_dat_o        <= '0;
      inject_o        <= 1'b0;
      inject_sample_o <= '0;
    end else begin
      wb_ack_o <= req;
      inject_o <= 1'b0;
      if (req) begin
        if (wb_we_i) begin
          wb_dat_o <= '0;
          // sample write becomes a one-cycle pulse
          if (wb_off_i == REG_SAMPLE) begin
            inject_o        <= 1'b1;
            inject_sample_o <= wb_dat_i[SAMPLE_W-1:0];
          end
        end else begin
          case (wb_off_i)
            REG_STATUS: wb_dat_o <= wb_data_t'({overrun_q, busy_i});
            REG_Y_LO:   wb_dat_o <= y_q[WB_DAT_W-1:0];
            // upper result bits, zero-extended
            REG_Y_HI:   wb_dat_o <= wb_data_t'(y_q[ACC_W-1:WB_DAT_W]);
            REG_SHIFT:  wb_dat_o <= wb_data_t'(shift_q);
            default:    wb_dat_o <= '0;
          endcase
        end
      end
    end
  end

  // sticky overrun, new drop beats a clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      overrun_q <= 1'b0;
      y_q       <= '0;
      shift_q   <= '0;
    end else begin
      if (drop_i) begin
        overrun_q <= 1'b1;
      end else if (req && wb_we_i && wb_off_i == REG_STATUS) begin
        overrun_q <= 1'b0;
      end
      // result snapshot for readback
      if (y_valid_i) begin
        y_q     <= y_i;
        shift_q <= shift_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- fir_engine.sv
`timescale 1ns/1ps
`default_nettype none

module fir_engine
  import fir_dsp_pkg::*;
#(
  parameter int unsigned LOG2_TAPS = 4
) (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire                  valid_i,
  input  wire sample_t         sample_i,
  input  wire                  inject_i,
  input  wire sample_t         inject_sample_i,
  output logic                 smp_wr_en_o,
  output logic [LOG2_TAPS-1:0] smp_wr_idx_o,
  output sample_t              smp_wr_data_o,
  output logic [LOG2_TAPS-1:0] smp_rd_idx_o,
  input  wire sample_t         smp_rd_data_i,
  output logic [LOG2_TAPS-1:0] coef_rd_idx_o,
  input  wire coeff_t          coef_rd_data_i,
  output acc_t                 y_o,
  output logic                 y_valid_o,
  output sample_t              shift_o,
  output logic                 busy_o,
  output logic                 drop_o
);

  typedef enum logic [2:0] {IDLE, WRITE, FETCH, DRAIN, DONE} state_t;

  state_t               state_q;
  logic                 valid_q;
  logic                 pin_rise;
  logic                 arrive;
  logic                 accept;
  sample_t              sample_q;
  logic [LOG2_TAPS-1:0] wr_ptr_q;
  logic [LOG2_TAPS-1:0] rd_idx_q;
  logic [LOG2_TAPS-1:0] coef_idx_q;
  logic                 mac_en_q;
  acc_t                 acc_q;
  acc_t                 product;
  sample_t              oldest_q;

  // pin edge or bus injection, only taken when idle
  assign pin_rise = valid_i & ~valid_q;
  assign arrive   = pin_rise | inject_i;
  assign busy_o   = (state_q != IDLE);
  assign accept   = arrive & ~busy_o;

  assign smp_wr_en_o   = (state_q == WRITE);
  assign smp_wr_idx_o  = wr_ptr_q;
  assign smp_wr_data_o = sample_q;
  assign smp_rd_idx_o  = rd_idx_q;
  assign coef_rd_idx_o = coef_idx_q;
  // both memory outputs are already registered
  assign product = acc_t'(smp_rd_data_i) * acc_t'(coef_rd_data_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      drop_o   <= 1'b0;
      sample_q <= '0;
    end else begin
      valid_q <= valid_i;
      // pin loses to injection in the same cycle
      drop_o  <= (pin_rise & inject_i) | (arrive & busy_o);
      if (accept) begin
        sample_q <= inject_i ? inject_sample_i : sample_i;
      end
    end
  end

  // address walk, samples newest first, coefficients from 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      wr_ptr_q   <= '0;
      rd_idx_q   <= '0;
      coef_idx_q <= '0;
    end else begin
      case (state_q)
        IDLE: if (accept) state_q <= WRITE;
        WRITE: begin
          wr_ptr_q   <= wr_ptr_q + 1'b1;
          rd_idx_q   <= wr_ptr_q;
          coef_idx_q <= '0;
          state_q    <= FETCH;
        end
        FETCH: begin
          // wraps modulo taps
          rd_idx_q   <= rd_idx_q - 1'b1;
          coef_idx_q <= coef_idx_q + 1'b1;
          if (coef_idx_q == '1) state_q <= DRAIN;
        end
        DRAIN:   state_q <= DONE;
        DONE:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // accumulate one cycle behind the reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mac_en_q  <= 1'b0;
      acc_q     <= '0;
      oldest_q  <= '0;
      y_o       <= '0;
      shift_o   <= '0;
      y_valid_o <= 1'b0;
    end else begin
      mac_en_q  <= (state_q == FETCH);
      y_valid_o <= 1'b0;
      if (accept) begin
        acc_q <= '0;
      end else if (mac_en_q) begin
        acc_q <= acc_q + product;
      end
      // last read of the window is the oldest sample
      if (state_q == DRAIN) oldest_q <= smp_rd_data_i;
      if (state_q == DONE) begin
        y_o       <= acc_q;
        shift_o   <= oldest_q;
        y_valid_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- fir_top.sv
`timescale 1ns/1ps
`default_nettype none

module fir_top
  import fir_dsp_pkg::*;
  import fir_bus_pkg::*;
#(
  parameter int unsigned LOG2_TAPS = 4
) (
  input  wire           clk_i,
  input  wire           rst_ni,
  // sample stream
  input  wire           valid_i,
  input  wire sample_t  sample_i,
  output acc_t          y_o,
  output logic          y_valid_o,
  output sample_t       shift_o,
  // wishbone classic target
  input  wire           wb_cyc_i,
  input  wire           wb_stb_i,
  input  wire           wb_we_i,
  input  wire wb_adr_t  wb_adr_i,
  input  wire wb_data_t wb_dat_i,
  output wb_data_t      wb_dat_o,
  output logic          wb_ack_o
);

  logic [2:0]           sel;
  logic [3:0]           wb_off;
  wb_data_t             dat_regs;
  wb_data_t             dat_smp;
  wb_data_t             dat_coef;
  logic                 ack_regs;
  logic                 ack_smp;
  logic                 ack_coef;
  logic                 inject;
  sample_t              inject_sample;
  logic                 busy;
  logic                 drop;
  logic                 smp_wr_en;
  logic [LOG2_TAPS-1:0] smp_wr_idx;
  sample_t              smp_wr_data;
  logic [LOG2_TAPS-1:0] smp_rd_idx;
  sample_t              smp_rd_data;
  logic [LOG2_TAPS-1:0] coef_rd_idx;
  coeff_t               coef_rd_data;

  // word offset shared by every target
  assign wb_off = wb_adr_i[5:2];

  wb_region_decode u_decode (
    .clk_i, .rst_ni, .cyc_i(wb_cyc_i), .stb_i(wb_stb_i), .adr_i(wb_adr_i), .sel_o(sel),
    .dat_regs_i(dat_regs), .dat_smp_i(dat_smp), .dat_coef_i(dat_coef),
    .ack_regs_i(ack_regs), .ack_smp_i(ack_smp), .ack_coef_i(ack_coef),
    .dat_o(wb_dat_o), .ack_o(wb_ack_o)
  );

  fir_regs u_regs (
    .clk_i, .rst_ni, .wb_sel_i(sel[0]), .wb_we_i, .wb_off_i(wb_off), .wb_dat_i,
    .wb_dat_o(dat_regs), .wb_ack_o(ack_regs),
    .inject_o(inject), .inject_sample_o(inject_sample),
    .busy_i(busy), .drop_i(drop), .y_valid_i(y_valid_o), .y_i(y_o), .shift_i(shift_o)
  );

  fir_sample_ram #(.LOG2_TAPS(LOG2_TAPS)) u_sample_ram (
    .clk_i, .rst_ni, .wr_en_i(smp_wr_en), .wr_idx_i(smp_wr_idx), .wr_data_i(smp_wr_data),
    .rd_idx_i(smp_rd_idx), .rd_data_o(smp_rd_data),
    .wb_sel_i(sel[1]), .wb_we_i, .wb_off_i(wb_off), .wb_dat_o(dat_smp), .wb_ack_o(ack_smp)
  );

  fir_coeff_ram #(.LOG2_TAPS(LOG2_TAPS)) u_coeff_ram (
    .clk_i, .rst_ni, .rd_idx_i(coef_rd_idx), .rd_data_o(coef_rd_data),
    .wb_sel_i(sel[2]), .wb_we_i, .wb_off_i(wb_off), .wb_dat_i,
    .wb_dat_o(dat_coef), .wb_ack_o(ack_coef)
  );

  fir_engine #(.LOG2_TAPS(LOG2_TAPS)) u_engine (
    .clk_i, .rst_ni, .valid_i, .sample_i, .inject_i(inject), .inject_sample_i(inject_sample),
    .smp_wr_en_o(smp_wr_en), .smp_wr_idx_o(smp_wr_idx), .smp_wr_data_o(smp_wr_data),
    .smp_rd_idx_o(smp_rd_idx), .smp_rd_data_i(smp_rd_data),
    .coef_rd_idx_o(coef_rd_idx), .coef_rd_data_i(coef_rd_data),
    .y_o, .y_valid_o, .shift_o, .busy_o(busy), .drop_o(drop)
  );

endmodule

`default_nettype wire

//--- tb_fir_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fir_top
  import fir_dsp_pkg::*;
  import fir_bus_pkg::*;
();

  localparam int LOG2_TAPS = 4;
  localparam int TAPS = 2 ** LOG2_TAPS;
  // drive edge to accepting edge is one, then taps plus three to the result
  localparam int RESULT_EDGES = TAPS + 4;
  localparam int WAIT_LIMIT = 64;

  logic     clk_i;
  logic     rst_ni;
  logic     valid_i;
  sample_t  sample_i;
  acc_t     y_o;
  logic     y_valid_o;
  sample_t  shift_o;
  logic     wb_cyc_i;
  logic     wb_stb_i;
  logic     wb_we_i;
  wb_adr_t  wb_adr_i;
  wb_data_t wb_dat_i;
  wb_data_t wb_dat_o;
  logic     wb_ack_o;

  // reference model, coefficients and circular sample history
  coeff_t  coef_m [TAPS];
  sample_t mem_m [TAPS];
  int      wptr_m;

  logic [31:0] rng;
  int          cycle_cnt;
  int          errors;
  int          checks;
  int          mark;
  int          tests_run;
  int          tests_failed;

  fir_top #(.LOG2_TAPS(LOG2_TAPS)) fir_top_inst (
    .clk_i, .rst_ni, .valid_i, .sample_i, .y_o, .y_valid_o, .shift_o,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o
  );

  always #2 clk_i = ~clk_i;

  // counts rising edges for latency checks
  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // ack and y_valid_o are single-cycle pulses
  assert property (@(posedge clk_i) disable iff (!rst_ni) wb_ack_o |=> !wb_ack_o)
    else begin
      $display("wb_ack_o stayed high for more than one cycle");
      errors++;
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) y_valid_o |=> !y_valid_o)
    else begin
      $display("y_valid_o stayed high for more than one cycle");
      errors++;
    end
  // no ack without a request the cycle before
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   $rose(wb_ack_o) |-> $past(wb_cyc_i & wb_stb_i))
    else begin
      $display("wb_ack_o rose without a pending request");
      errors++;
    end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // region in bits 7:6, word offset in bits 5:2
  function automatic wb_adr_t word_adr(input logic [1:0] region, input logic [3:0] off);
    return {region, off, 2'b00};
  endfunction

  task automatic check_value(input string name, input acc_t got, input acc_t exp);
    checks++;
    assert (got === exp)
    else begin
      $display("FAILED %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  // one classic cycle, held until ack
  task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_data_t wdat,
                           output wb_data_t rdat);
    int n;
    n = 0;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    do begin
      @(negedge clk_i);
      n++;
    end while (!wb_ack_o && n < WAIT_LIMIT);
    assert (wb_ack_o)
    else begin
      $display("no ack from the bus at address %h", adr);
      errors++;
    end
    check_value("wb_ack_o latency", acc_t'(n), acc_t'(1));
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic read_expect(input string name, input wb_adr_t adr, input wb_data_t exp);
    wb_data_t rd;
    bus_cycle(1'b0, adr, '0, rd);
    check_value(name, acc_t'(rd), acc_t'(exp));
  endtask

  task automatic write_word(input wb_adr_t adr, input wb_data_t dat);
    wb_data_t rd;
    bus_cycle(1'b1, adr, dat, rd);
  endtask

  // sample lands where the engine's write pointer points
  task automatic model_push(input sample_t s);
    mem_m[wptr_m] = s;
    wptr_m = (wptr_m + 1) % TAPS;
  endtask

  // sum of coeff[k] * x[n-k], newest at wptr_m-1
  function automatic acc_t model_y();
    acc_t sum;
    sum = '0;
    for (int k = 0; k < TAPS; k++) begin
      sum += acc_t'(coef_m[k]) * acc_t'(mem_m[(wptr_m - 1 - k + 2 * TAPS) % TAPS]);
    end
    return sum;
  endfunction

  // one-cycle pulse on valid_i, start is the edge count at the drive
  task automatic pulse_valid(input sample_t s, output int start);
    @(negedge clk_i);
    valid_i  = 1'b1;
    sample_i = s;
    start    = cycle_cnt;
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  task automatic expect_result(input int start);
    int n;
    acc_t y_exp;
    n = 0;
    y_exp = model_y();
    while (!y_valid_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    assert (y_valid_o)
    else begin
      $display("y_valid_o never came for the sample accepted at edge %0d", start);
      errors++;
    end
    check_value("y_valid_o latency", acc_t'(cycle_cnt - start), acc_t'(RESULT_EDGES));
    check_value("y_o", y_o, y_exp);
    // x[n-TAPS+1] sits just past the newest entry
    check_value("shift_o", acc_t'(shift_o), acc_t'(mem_m[wptr_m]));
    read_expect("REG_Y_LO", word_adr(REGION_REGS, REG_Y_LO), y_exp[31:0]);
    read_expect("REG_Y_HI", word_adr(REGION_REGS, REG_Y_HI), wb_data_t'(y_exp[39:32]));
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors > mark) begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - mark);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    mark = errors;
  endtask

  initial begin
    int start;
    int seen;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    valid_i = 1'b0;
    sample_i = '0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    cycle_cnt = 0;
    errors = 0;
    checks = 0;
    mark = 0;
    tests_run = 0;
    tests_failed = 0;
    wptr_m = 0;
    rng = 32'h9d0f;
    for (int i = 0; i < TAPS; i++) begin
      coef_m[i] = '0;
      mem_m[i] = '0;
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // reset values and the unmapped region
    check_value("y_valid_o", acc_t'(y_valid_o), '0);
    check_value("wb_ack_o", acc_t'(wb_ack_o), '0);
    read_expect("REG_STATUS", word_adr(REGION_REGS, REG_STATUS), '0);
    read_expect("REG_Y_LO", word_adr(REGION_REGS, REG_Y_LO), '0);
    read_expect("coeff 0", word_adr(REGION_COEFFS, 4'd0), '0);
    read_expect("unmapped read", word_adr(2'd3, 4'd2), '0);
    report_test("reset state");

    // only the low half of a coefficient write is kept
    for (int i = 0; i < TAPS; i++) begin
      rng = xorshift(rng);
      coef_m[i] = rng[15:0];
      write_word(word_adr(REGION_COEFFS, 4'(i)), rng);
    end
    for (int i = 0; i < TAPS; i++) begin
      read_expect("coeff readback", word_adr(REGION_COEFFS, 4'(i)), wb_data_t'(coef_m[i]));
    end
    report_test("coefficient load");

    // next drive lands 25 edges after the previous one
    for (int s = 0; s < 20; s++) begin
      rng = xorshift(rng);
      model_push(rng[15:0]);
      pulse_valid(rng[15:0], start);
      expect_result(start);
      while (cycle_cnt - start < 24) @(negedge clk_i);
    end
    for (int i = 0; i < TAPS; i++) begin
      read_expect("sample memory", word_adr(REGION_SAMPLES, 4'(i)), wb_data_t'(mem_m[i]));
    end
    read_expect("REG_SHIFT", word_adr(REGION_REGS, REG_SHIFT), wb_data_t'(mem_m[wptr_m]));
    report_test("stream samples");

    // bus injection, upper data bits ignored
    rng = xorshift(rng);
    model_push(rng[15:0]);
    write_word(word_adr(REGION_REGS, REG_SAMPLE), rng);
    start = cycle_cnt;
    expect_result(start);
    report_test("bus sample");

    // second rise while busy gets dropped
    rng = xorshift(rng);
    model_push(rng[15:0]);
    pulse_valid(rng[15:0], start);
    @(negedge clk_i);
    rng = xorshift(rng);
    pulse_valid(rng[15:0], seen);
    @(negedge clk_i);
    read_expect("REG_STATUS busy", word_adr(REGION_REGS, REG_STATUS), 32'h3);
    expect_result(start);
    seen = 0;
    repeat (30) begin
      @(negedge clk_i);
      if (y_valid_o) seen++;
    end
    check_value("extra y_valid_o", acc_t'(seen), '0);
    read_expect("REG_STATUS overrun", word_adr(REGION_REGS, REG_STATUS), 32'h2);
    write_word(word_adr(REGION_REGS, REG_STATUS), '0);
    read_expect("REG_STATUS cleared", word_adr(REGION_REGS, REG_STATUS), '0);
    rng = xorshift(rng);
    model_push(rng[15:0]);
    pulse_valid(rng[15:0], start);
    expect_result(start);
    report_test("overrun");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
fir_dsp_pkg.sv
fir_bus_pkg.sv
wb_region_decode.sv
fir_sample_ram.sv
fir_coeff_ram.sv
fir_regs.sv
fir_engine.sv
fir_top.sv
tb_fir_top.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_fir_top
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Testbench failed
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# a crashed run counts as a failure
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
